// File: Bender.yml
package:
  name: row_conn

sources:
  - common/row_conn_pkg.sv
  - hw/row_conn/ctx_mem.sv
  - hw/row_conn/ctx_sequencer.sv
  - hw/row_conn/route_xbar.sv
  - hw/row_conn/row_conn_top.sv
  - target: simulation
    files:
      - verif/tb_clk_gen.sv
      - verif/row_conn_chk.sv
      - verif/row_conn_tb.sv

// File: common/row_conn_pkg.sv
// --------------------
// Widths, select field layout and shared types of the row connection unit
// --------------------
`default_nettype none

package row_conn_pkg;

	// One data word on every source and lane
	parameter int DWORD_W = 64;

	// Unit field sits above the context address bits
	parameter int PE_NUM_W       = 2;
	parameter int CTX_ADDR_W_DEF = 5;    // 32 context words

	// Sources seen by the crossbar
	parameter int N_PE         = 4;
	parameter int WORDS_PER_PE = 12;    // 4 S48, 4 B16, 4 B8
	parameter int N_SRC        = N_PE * WORDS_PER_PE;

	parameter int N_LANE = 4;    // Lanes per group

	// Select widths per lane group
	parameter int D48_SEL_W = 6;
	parameter int B16_SEL_W = 4;
	parameter int B8_SEL_W  = 3;

	// Field groups packed from bit 0 upward: B8, B16, then D48
	// Inside a group lane 3 takes the lowest field
	parameter int B8_SEL_LSB  = 0;
	parameter int B16_SEL_LSB = B8_SEL_LSB + N_LANE * B8_SEL_W;
	parameter int D48_SEL_LSB = B16_SEL_LSB + N_LANE * B16_SEL_W;
	parameter int CTX_W       = D48_SEL_LSB + N_LANE * D48_SEL_W;

	// B8 lanes only reach PE0 words 4..11
	parameter int B8_SRC_BASE = 4;

	typedef logic [DWORD_W-1:0] dword_t;
	typedef logic [CTX_W-1:0]   ctx_word_t;

	// Run sequencing
	typedef enum logic [1:0] {
		SEQ_IDLE,     // Waiting for start
		SEQ_EXEC,     // Reading context words
		SEQ_DRAIN,    // Last beats leaving the pipeline
		SEQ_DONE      // done held until start drops
	} seq_state_e;

endpackage

`default_nettype wire

// File: flist.f
common/row_conn_pkg.sv
hw/row_conn/ctx_mem.sv
hw/row_conn/ctx_sequencer.sv
hw/row_conn/route_xbar.sv
hw/row_conn/row_conn_top.sv
verif/tb_clk_gen.sv
verif/row_conn_chk.sv
verif/row_conn_tb.sv

// File: hw/row_conn/ctx_mem.sv
// --------------------
// Context RAM with unit match on writes and last address capture
// --------------------
`default_nettype none

module ctx_mem #(
	parameter int UNIT_NO    = 0,
	parameter int CTX_ADDR_W = row_conn_pkg::CTX_ADDR_W_DEF
) (
	input  wire logic                                          CLK,
	input  wire logic                                          RST,
	input  wire logic                                          ctx_wr_en,
	input  wire logic [row_conn_pkg::PE_NUM_W+CTX_ADDR_W-1:0]  ctx_wr_addr,
	input  wire row_conn_pkg::ctx_word_t                       ctx_wr_data,
	input  wire logic                                          rd_en,
	input  wire logic [CTX_ADDR_W-1:0]                         rd_addr,
	output row_conn_pkg::ctx_word_t                            rd_data,
	output logic      [CTX_ADDR_W-1:0]                         last_addr
);
	import row_conn_pkg::*;

	ctx_word_t mem [2**CTX_ADDR_W];
	logic      wr_hit;

	// Only writes addressed to this unit land here
	assign wr_hit = ctx_wr_en &&
		(ctx_wr_addr[PE_NUM_W+CTX_ADDR_W-1 -: PE_NUM_W] == PE_NUM_W'(UNIT_NO));

	always_ff @(posedge CLK) begin
		if (wr_hit) begin
			mem[ctx_wr_addr[CTX_ADDR_W-1:0]] <= ctx_wr_data;
		end
	end

	// Registered read, data one cycle after rd_en
	always_ff @(posedge CLK) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

	// Run end point follows the most recent matched write
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			last_addr <= '0;
		end else if (wr_hit) begin
			last_addr <= ctx_wr_addr[CTX_ADDR_W-1:0];
		end
	end

endmodule

`default_nettype wire

// File: hw/row_conn/ctx_sequencer.sv
// --------------------
// Run FSM: context address stepping, drain count, start/done handshake
// --------------------
`default_nettype none

module ctx_sequencer #(
	parameter int CTX_ADDR_W = row_conn_pkg::CTX_ADDR_W_DEF
) (
	input  wire logic                  CLK,
	input  wire logic                  RST,
	input  wire logic                  start,
	input  wire logic                  step,
	input  wire logic [CTX_ADDR_W-1:0] last_addr,
	output logic                       rd_en,
	output logic      [CTX_ADDR_W-1:0] rd_addr,
	output logic                       ctx_valid,
	output logic                       done
);
	import row_conn_pkg::*;

	// Cycles between the last read and done, covers RAM and output stage
	localparam int DRAIN_CYC = 2;
	localparam int DRAIN_W   = $clog2(DRAIN_CYC);

	seq_state_e         state;
	seq_state_e         state_nxt;
	logic [DRAIN_W-1:0] drain_cnt;
	logic               last_rd;
	logic               drain_end;

	assign rd_en     = (state == SEQ_EXEC);    // One read every EXEC cycle
	assign done      = (state == SEQ_DONE);
	assign last_rd   = rd_en && step && (rd_addr == last_addr);
	assign drain_end = (drain_cnt == DRAIN_W'(DRAIN_CYC - 1));

	always_comb begin
		state_nxt = state;
		case (state)
			SEQ_IDLE: begin
				if (start) begin
					state_nxt = SEQ_EXEC;
				end
			end
			SEQ_EXEC: begin
				if (last_rd) begin
					state_nxt = SEQ_DRAIN;
				end
			end
			SEQ_DRAIN: begin
				// An aborted request skips done entirely
				if (drain_end) begin
					state_nxt = start ? SEQ_DONE : SEQ_IDLE;
				end
			end
			SEQ_DONE: begin
				if (!start) begin
					state_nxt = SEQ_IDLE;    // done falls on this edge
				end
			end
			default: begin
				state_nxt = SEQ_IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			state <= SEQ_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Held address is read again, so its beat repeats
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			rd_addr <= '0;
		end else if (rd_en && step) begin
			rd_addr <= rd_addr + 1'b1;
		end else if (state_nxt == SEQ_IDLE) begin
			rd_addr <= '0;    // Next run starts from entry 0
		end
	end

	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			drain_cnt <= '0;
		end else if (state == SEQ_DRAIN) begin
			drain_cnt <= drain_cnt + 1'b1;
		end else begin
			drain_cnt <= '0;
		end
	end

	// RAM data is valid one cycle after the read
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			ctx_valid <= 1'b0;
		end else begin
			ctx_valid <= rd_en;
		end
	end

endmodule

`default_nettype wire

// File: hw/row_conn/route_xbar.sv
// --------------------
// Select field decode and registered twelve-lane source crossbar
// --------------------
`default_nettype none

module route_xbar (
	input  wire logic                                                 CLK,
	input  wire logic                                                 RST,
	input  wire row_conn_pkg::ctx_word_t                              rd_data,
	input  wire logic                                                 ctx_valid,
	input  wire row_conn_pkg::dword_t [row_conn_pkg::N_SRC-1:0]       src,
	output row_conn_pkg::dword_t      [row_conn_pkg::N_LANE-1:0]      d48_out,
	output row_conn_pkg::dword_t      [row_conn_pkg::N_LANE-1:0]      b16_out,
	output row_conn_pkg::dword_t      [row_conn_pkg::N_LANE-1:0]      b8_out,
	output logic                                                      out_valid
);
	import row_conn_pkg::*;

	logic   [D48_SEL_W-1:0] d48_sel [N_LANE];
	logic   [B16_SEL_W-1:0] b16_sel [N_LANE];
	logic   [B8_SEL_W-1:0]  b8_sel  [N_LANE];
	logic   [D48_SEL_W-1:0] d48_idx [N_LANE];
	dword_t [N_LANE-1:0]    d48_nxt;
	dword_t [N_LANE-1:0]    b16_nxt;
	dword_t [N_LANE-1:0]    b8_nxt;

	// Lane 0 sits in the highest field of each group
	always_comb begin
		for (int i = 0; i < N_LANE; i++) begin
			d48_sel[i] = rd_data[D48_SEL_LSB + (N_LANE - 1 - i) * D48_SEL_W +: D48_SEL_W];
			b16_sel[i] = rd_data[B16_SEL_LSB + (N_LANE - 1 - i) * B16_SEL_W +: B16_SEL_W];
			b8_sel[i]  = rd_data[B8_SEL_LSB + (N_LANE - 1 - i) * B8_SEL_W +: B8_SEL_W];
		end
	end

	// Upper half of the D48 select only decodes 4 bits
	// so 48..63 alias onto sources 32..47
	always_comb begin
		for (int i = 0; i < N_LANE; i++) begin
			if (d48_sel[i][D48_SEL_W-1]) begin
				d48_idx[i] = {2'b10, d48_sel[i][3:0]};
			end else begin
				d48_idx[i] = d48_sel[i];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < N_LANE; i++) begin
			d48_nxt[i] = src[d48_idx[i]];
			b16_nxt[i] = src[b16_sel[i]];          // First 16 sources only
			b8_nxt[i]  = src[B8_SRC_BASE + b8_sel[i]];
		end
	end

	// Lanes read zero whenever no fresh context word is present
	always_ff @(posedge CLK or negedge RST) begin
		if (!RST) begin
			d48_out   <= '0;
			b16_out   <= '0;
			b8_out    <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= ctx_valid;
			if (ctx_valid) begin
				d48_out <= d48_nxt;
				b16_out <= b16_nxt;
				b8_out  <= b8_nxt;
			end else begin
				d48_out <= '0;
				b16_out <= '0;
				b8_out  <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/row_conn/row_conn_top.sv
// --------------------
// Row connection unit top: context memory, sequencer and crossbar
// --------------------
`default_nettype none

module row_conn_top #(
	parameter int UNIT_NO    = 0,
	parameter int CTX_ADDR_W = row_conn_pkg::CTX_ADDR_W_DEF
) (
	input  wire logic                                            CLK,
	input  wire logic                                            RST,

	// Host context writes, unit field in the top address bits
	input  wire logic [row_conn_pkg::PE_NUM_W+CTX_ADDR_W-1:0]    ctx_wr_addr,
	input  wire logic                                            ctx_wr_en,
	input  wire row_conn_pkg::ctx_word_t                         ctx_wr_data,

	// Run control, start is a four-phase request acknowledged by done
	input  wire logic                                            start,
	input  wire logic                                            step,

	// S48, B16 and B8 words of the four PEs
	input  wire row_conn_pkg::dword_t [row_conn_pkg::N_SRC-1:0]  src,

	output row_conn_pkg::dword_t      [row_conn_pkg::N_LANE-1:0] d48_out,
	output row_conn_pkg::dword_t      [row_conn_pkg::N_LANE-1:0] b16_out,
	output row_conn_pkg::dword_t      [row_conn_pkg::N_LANE-1:0] b8_out,
	output logic                                                 out_valid,
	output logic                                                 done
);
	import row_conn_pkg::*;

	logic [CTX_ADDR_W-1:0] last_addr;
	logic                  rd_en;
	logic [CTX_ADDR_W-1:0] rd_addr;
	ctx_word_t             rd_data;
	logic                  ctx_valid;    // rd_data holds a freshly read word

	ctx_mem #(
		.UNIT_NO    (UNIT_NO),
		.CTX_ADDR_W (CTX_ADDR_W)
	) u_ctx_mem (
		.CLK         (CLK),
		.RST         (RST),
		.ctx_wr_en   (ctx_wr_en),
		.ctx_wr_addr (ctx_wr_addr),
		.ctx_wr_data (ctx_wr_data),
		.rd_en       (rd_en),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.last_addr   (last_addr)
	);

	ctx_sequencer #(
		.CTX_ADDR_W (CTX_ADDR_W)
	) u_ctx_sequencer (
		.CLK       (CLK),
		.RST       (RST),
		.start     (start),
		.step      (step),
		.last_addr (last_addr),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.ctx_valid (ctx_valid),
		.done      (done)
	);

	// Beat leaves two cycles after its context read
	route_xbar u_route_xbar (
		.CLK       (CLK),
		.RST       (RST),
		.rd_data   (rd_data),
		.ctx_valid (ctx_valid),
		.src       (src),
		.d48_out   (d48_out),
		.b16_out   (b16_out),
		.b8_out    (b8_out),
		.out_valid (out_valid)
	);

endmodule

`default_nettype wire

// File: verif/row_conn_chk.sv
// --------------------
// Bound assertions on the start/done handshake and idle lanes
// --------------------
`default_nettype none

module row_conn_chk (
	input wire logic                                            CLK,
	input wire logic                                            RST,
	input wire logic                                            start,
	input wire logic                                            done,
	input wire logic                                            out_valid,
	input wire row_conn_pkg::dword_t [row_conn_pkg::N_LANE-1:0] d48_out,
	input wire row_conn_pkg::dword_t [row_conn_pkg::N_LANE-1:0] b16_out,
	input wire row_conn_pkg::dword_t [row_conn_pkg::N_LANE-1:0] b8_out
);

	int fail_cnt = 0;    // Failed assertions so far

	// done acknowledges a request that is still up
	done_rise_a: assert property (@(posedge CLK) disable iff (!RST)
		$rose(done) |-> start)
		else begin
			$error("done rose while start was low");
			fail_cnt++;
		end

	done_fall_a: assert property (@(posedge CLK) disable iff (!RST)
		$fell(done) |-> $past(!start))
		else begin
			$error("done fell while start was still high");
			fail_cnt++;
		end

	// Last beat leaves one cycle before done
	valid_done_a: assert property (@(posedge CLK) disable iff (!RST)
		!(out_valid && done))
		else begin
			$error("out_valid and done high in the same cycle");
			fail_cnt++;
		end

	idle_zero_a: assert property (@(posedge CLK) disable iff (!RST)
		!out_valid |-> (d48_out == '0 && b16_out == '0 && b8_out == '0))
		else begin
			$error("lane data not zero while out_valid is low");
			fail_cnt++;
		end

endmodule

bind row_conn_top row_conn_chk u_row_conn_chk (
	.CLK       (CLK),
	.RST       (RST),
	.start     (start),
	.done      (done),
	.out_valid (out_valid),
	.d48_out   (d48_out),
	.b16_out   (b16_out),
	.b8_out    (b8_out)
);

`default_nettype wire

// File: verif/row_conn_tb.sv
// --------------------
// Row connection unit testbench: test table, host writes, routing model
// --------------------
`default_nettype none

module row_conn_tb;
	import row_conn_pkg::*;

	localparam int UNIT_NO    = 1;
	localparam int CTX_ADDR_W = CTX_ADDR_W_DEF;
	localparam int CTX_DEPTH  = 2**CTX_ADDR_W;
	localparam int N_TESTS    = 6;
	localparam int RUN_TMO    = 300;    // Cycles
	localparam int WAIT_TMO   = 20;
	localparam int GRP_D48    = 0;
	localparam int GRP_B16    = 1;
	localparam int GRP_B8     = 2;

	logic                           CLK;
	logic                           RST;
	logic                           ctx_wr_en;
	logic [PE_NUM_W+CTX_ADDR_W-1:0] ctx_wr_addr;
	ctx_word_t                      ctx_wr_data;
	logic                           start;
	logic                           step;
	dword_t [N_SRC-1:0]             src;
	dword_t [N_LANE-1:0]            d48_out;
	dword_t [N_LANE-1:0]            b16_out;
	dword_t [N_LANE-1:0]            b8_out;
	logic                           out_valid;
	logic                           done;

	string       t_name     [N_TESTS];
	int          t_entries  [N_TESTS];
	int          t_unit     [N_TESTS];
	logic [31:0] t_step_pat [N_TESTS];    // Bit c drives step in EXEC cycle c
	bit          t_oor      [N_TESTS];
	int          t_beats    [N_TESTS];

	// Host copy of what the unit should hold
	ctx_word_t   ctx_copy [CTX_DEPTH];
	int          last_copy;
	dword_t      src_copy [N_SRC];
	int          exp_addr [$];
	logic [31:0] rng;
	int          chk_cnt;
	int          err_cnt;
	int          tmo_cnt;

	tb_clk_gen u_clk_gen (
		.CLK (CLK),
		.RST (RST)
	);

	row_conn_top #(
		.UNIT_NO    (UNIT_NO),
		.CTX_ADDR_W (CTX_ADDR_W)
	) DUT (
		.CLK         (CLK),
		.RST         (RST),
		.ctx_wr_addr (ctx_wr_addr),
		.ctx_wr_en   (ctx_wr_en),
		.ctx_wr_data (ctx_wr_data),
		.start       (start),
		.step        (step),
		.src         (src),
		.d48_out     (d48_out),
		.b16_out     (b16_out),
		.b8_out      (b8_out),
		.out_valid   (out_valid),
		.done        (done)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_rand(output logic [31:0] r);
		rng = xorshift32(rng);
		r   = rng;
	endtask

	task automatic add_test_row(input int idx, input string name, input int entries,
			input int unit, input logic [31:0] step_pat, input bit oor, input int beats);
		t_name[idx]     = name;
		t_entries[idx]  = entries;
		t_unit[idx]     = unit;
		t_step_pat[idx] = step_pat;
		t_oor[idx]      = oor;
		t_beats[idx]    = beats;
	endtask

	// Pattern runs out after 32 cycles, then step stays high
	function automatic logic step_bit(input logic [31:0] pat, input int cyc);
		return (cyc < 32) ? pat[cyc] : 1'b1;
	endfunction

	// Source index for one lane, lane 0 in the highest field of its group
	function automatic int lane_source(input ctx_word_t ctx, input int grp, input int lane);
		int pos;
		int sel;
		if (grp == GRP_D48) begin
			pos = D48_SEL_LSB + (N_LANE - 1 - lane) * D48_SEL_W;
			sel = int'((ctx >> pos) & ((1 << D48_SEL_W) - 1));
			return (sel >= 48) ? 32 + (sel % 16) : sel;    // Upper selects alias
		end else if (grp == GRP_B16) begin
			pos = B16_SEL_LSB + (N_LANE - 1 - lane) * B16_SEL_W;
			return int'((ctx >> pos) & ((1 << B16_SEL_W) - 1));
		end
		pos = B8_SEL_LSB + (N_LANE - 1 - lane) * B8_SEL_W;
		return B8_SRC_BASE + int'((ctx >> pos) & ((1 << B8_SEL_W) - 1));
	endfunction

	task automatic report_value(input string tname, input string what, input int beat,
			input int lane, input dword_t exp, input dword_t act);
		err_cnt++;
		$display("FAILED %s beat %0d %s[%0d]: expected %h, actual %h",
			tname, beat, what, lane, exp, act);
	endtask

	task automatic write_ctx(input int unit, input int addr, input ctx_word_t data);
		@(posedge CLK);
		ctx_wr_en   <= 1'b1;
		ctx_wr_addr <= {PE_NUM_W'(unit), CTX_ADDR_W'(addr)};
		ctx_wr_data <= data;
		@(posedge CLK);
		ctx_wr_en   <= 1'b0;
		if (unit == UNIT_NO) begin
			ctx_copy[addr] = data;
			last_copy      = addr;
		end
	endtask

	task automatic load_program(input int t);
		logic [31:0] r0;
		logic [31:0] r1;
		ctx_word_t   w;
		int          sel;
		for (int a = 0; a < t_entries[t]; a++) begin
			next_rand(r0);
			next_rand(r1);
			w = ctx_word_t'({r0, r1});
			if (t_oor[t]) begin
				for (int l = 0; l < N_LANE; l++) begin
					sel = 48 + int'((r0 >> (4 * l)) & 32'hf);
					w[D48_SEL_LSB + l * D48_SEL_W +: D48_SEL_W] = D48_SEL_W'(sel);
				end
			end
			write_ctx(t_unit[t], a, w);
		end
		for (int s = 0; s < N_SRC; s++) begin
			next_rand(r0);
			next_rand(r1);
			src_copy[s] = {r0, r1};
		end
		@(posedge CLK);
		for (int s = 0; s < N_SRC; s++) begin
			src[s] <= src_copy[s];
		end
	endtask

	// Addresses read in a run, one per EXEC cycle
	task automatic build_read_list(input logic [31:0] pat);
		int addr;
		int cyc;
		addr = 0;
		cyc  = 0;
		exp_addr.delete();
		while (cyc < RUN_TMO) begin
			exp_addr.push_back(addr);
			if (step_bit(pat, cyc)) begin
				if (addr == last_copy) begin
					break;
				end
				addr++;
			end
			cyc++;
		end
	endtask

	task automatic check_idle_outputs(input string tname);
		chk_cnt++;
		if (done !== 1'b0 || out_valid !== 1'b0) begin
			err_cnt++;
			$display("FAILED %s done/out_valid: expected 0/0, actual %b/%b",
				tname, done, out_valid);
		end
		for (int l = 0; l < N_LANE; l++) begin
			if (d48_out[l] !== 64'h0) begin
				report_value(tname, "idle d48", 0, l, 64'h0, d48_out[l]);
			end
			if (b16_out[l] !== 64'h0) begin
				report_value(tname, "idle b16", 0, l, 64'h0, b16_out[l]);
			end
			if (b8_out[l] !== 64'h0) begin
				report_value(tname, "idle b8", 0, l, 64'h0, b8_out[l]);
			end
		end
	endtask

	task automatic run_and_check(input int t);
		int        beats;
		int        cyc;
		bit        finished;
		ctx_word_t ctx;
		dword_t    exp;
		beats    = 0;
		cyc      = 0;
		finished = 1'b0;
		build_read_list(t_step_pat[t]);
		if (exp_addr.size() != t_beats[t]) begin
			err_cnt++;
			$display("ERROR: %s table beat count %0d disagrees with the step model %0d",
				t_name[t], t_beats[t], exp_addr.size());
		end
		@(posedge CLK);
		start <= 1'b1;
		step  <= 1'b1;
		while (!finished && cyc < RUN_TMO) begin
			@(posedge CLK);
			step <= step_bit(t_step_pat[t], cyc);
			cyc++;
			@(negedge CLK);
			if (out_valid) begin
				if (beats < exp_addr.size()) begin
					ctx = ctx_copy[exp_addr[beats]];
					for (int l = 0; l < N_LANE; l++) begin
						chk_cnt++;
						exp = src_copy[lane_source(ctx, GRP_D48, l)];
						if (d48_out[l] !== exp) begin
							report_value(t_name[t], "d48", beats, l, exp, d48_out[l]);
						end
						exp = src_copy[lane_source(ctx, GRP_B16, l)];
						if (b16_out[l] !== exp) begin
							report_value(t_name[t], "b16", beats, l, exp, b16_out[l]);
						end
						exp = src_copy[lane_source(ctx, GRP_B8, l)];
						if (b8_out[l] !== exp) begin
							report_value(t_name[t], "b8", beats, l, exp, b8_out[l]);
						end
					end
				end
				beats++;
			end else if (beats != 0 && !done) begin
				err_cnt++;
				$display("ERROR: %s beats stopped after %0d beats before done",
					t_name[t], beats);
			end
			if (done) begin
				finished = 1'b1;
			end
		end
		if (!finished) begin
			tmo_cnt++;
			$display("ERROR: %s timed out waiting for done", t_name[t]);
		end else begin
			chk_cnt++;
			if (beats != t_beats[t]) begin
				err_cnt++;
				$display("FAILED %s beat count: expected %0d, actual %0d",
					t_name[t], t_beats[t], beats);
			end
		end
	endtask

	// done must hold while start stays up, then fall
	task automatic release_start(input int t);
		int wait_cyc;
		repeat (2) begin
			@(posedge CLK);
			@(negedge CLK);
			chk_cnt++;
			if (done !== 1'b1) begin
				err_cnt++;
				$display("FAILED %s done hold: expected 1, actual %b", t_name[t], done);
			end
		end
		@(posedge CLK);
		start <= 1'b0;
		wait_cyc = 0;
		while (done && wait_cyc < WAIT_TMO) begin
			@(negedge CLK);
			wait_cyc++;
		end
		if (done) begin
			tmo_cnt++;
			$display("ERROR: %s timed out waiting for done to fall", t_name[t]);
		end else begin
			check_idle_outputs(t_name[t]);
		end
	endtask

	initial begin
		int wait_cyc;
		int asrt_cnt;
		ctx_wr_en   = 1'b0;
		ctx_wr_addr = '0;
		ctx_wr_data = '0;
		start       = 1'b0;
		step        = 1'b1;
		src         = '0;
		rng         = 32'h8666;
		last_copy   = 0;
		chk_cnt     = 0;
		err_cnt     = 0;
		tmo_cnt     = 0;

		// index, name, entries, unit, step pattern, D48 out of range, beats
		add_test_row(0, "full_step",    8,  1, 32'hffff_ffff, 1'b0, 8);
		add_test_row(1, "stall_pat",    6,  1, 32'hffff_ffcd, 1'b0, 9);
		add_test_row(2, "foreign_unit", 10, 2, 32'hffff_ffff, 1'b0, 6);
		add_test_row(3, "d48_oor",      5,  1, 32'hffff_ffff, 1'b1, 5);
		add_test_row(4, "rerun",        0,  1, 32'hffff_fffe, 1'b0, 6);
		add_test_row(5, "full_depth",   32, 1, 32'hffff_ffff, 1'b0, 32);

		wait_cyc = 0;
		while (RST !== 1'b1 && wait_cyc < 40) begin
			@(negedge CLK);
			wait_cyc++;
		end
		if (RST !== 1'b1) begin
			tmo_cnt++;
			$display("ERROR: reset was never released");
		end else begin
			@(negedge CLK);
			check_idle_outputs("reset");
			for (int t = 0; t < N_TESTS && tmo_cnt == 0; t++) begin
				load_program(t);
				run_and_check(t);
				if (tmo_cnt == 0) begin
					release_start(t);
				end
			end
		end

		asrt_cnt = DUT.u_row_conn_chk.fail_cnt;
		$display("Summary: %0d checks, %0d errors, %0d timeouts, %0d assertion failures",
			chk_cnt, err_cnt, tmo_cnt, asrt_cnt);
		if (err_cnt == 0 && tmo_cnt == 0 && asrt_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
// --------------------
// Testbench clock and active low reset
// --------------------
`default_nettype none

module tb_clk_gen #(
	parameter int HALF_PERIOD = 20,    // Period of 40
	parameter int RST_CYCLES  = 10
) (
	output logic CLK,
	output logic RST
);

	initial begin
		CLK = 1'b0;
		forever begin
			#HALF_PERIOD CLK = ~CLK;
		end
	end

	// Release away from the rising edge
	initial begin
		RST = 1'b0;
		repeat (RST_CYCLES) @(posedge CLK);
		@(negedge CLK);
		RST = 1'b1;
	end

endmodule

`default_nettype wire
